/* mmu_pkg.sv */
package mmu_pkg;

    // bus geometry
    localparam int WORD_W   = 32;
    localparam int SEG_W    = 3;
    localparam int OFFSET_W = WORD_W - SEG_W;

    typedef logic [WORD_W-1:0] word_t;  // data or address word
    typedef logic [SEG_W-1:0]  seg_t;   // address bits 31..29

    // unmapped kernel segments
    localparam seg_t SEG_KSEG0 = 3'b100;  // cached window
    localparam seg_t SEG_KSEG1 = 3'b101;  // uncached window

    // user segment is shifted up by a fixed amount
    localparam word_t KUSEG_OFFSET = 32'h4000_0000;

    // uncached register block size in words
    localparam int MMIO_WORDS = 16;

    typedef struct packed {
        seg_t                seg;
        logic [OFFSET_W-1:0] offset;
    } vaddr_fields_t;

    // one virtual address, seen as a plain word or split into segment and offset
    typedef union packed {
        word_t         raw;
        vaddr_fields_t f;
    } vaddr_u;

endpackage

/* sramx_if.sv */
`timescale 1ns/1ps

interface sramx_if;
    import mmu_pkg::*;

    // master side
    logic  req;
    logic  wr;     // 1 for store
    word_t addr;
    word_t wdata;

    // slave side
    logic  addr_ok;  // request accepted when req && addr_ok
    logic  data_ok;  // one per accepted request, in order
    word_t rdata;

    modport master (
        output req,
        output wr,
        output addr,
        output wdata,
        input  addr_ok,
        input  data_ok,
        input  rdata
    );

    modport slave (
        input  req,
        input  wr,
        input  addr,
        input  wdata,
        output addr_ok,
        output data_ok,
        output rdata
    );

endinterface

/* addr_translate.sv */
`timescale 1ns/1ps

module addr_translate (
    input  mmu_pkg::word_t i_vaddr,
    output mmu_pkg::word_t o_paddr,
    output logic           o_uncached
);
    import mmu_pkg::*;

    vaddr_u va;
    word_t  kuseg_paddr;
    word_t  kseg01_paddr;
    logic   is_kuseg;
    logic   is_kseg01;

    assign va = i_vaddr;

    // user segment sits at the bottom half of the address space
    assign is_kuseg  = !va.f.seg[SEG_W-1];
    assign is_kseg01 = (va.f.seg == SEG_KSEG0) || (va.f.seg == SEG_KSEG1);

    assign kuseg_paddr  = va.raw + KUSEG_OFFSET;
    assign kseg01_paddr = {{SEG_W{1'b0}}, va.f.offset};  // drop the segment bits

    always_comb begin
        o_paddr    = va.raw;  // kseg2/kseg3 map straight through
        o_uncached = 1'b0;
        if (is_kuseg) begin
            o_paddr = kuseg_paddr;
        end else if (is_kseg01) begin
            o_paddr    = kseg01_paddr;
            o_uncached = (va.f.seg == SEG_KSEG1);  // kseg1 bypasses the cache
        end
    end

endmodule

/* access_dispatch.sv */
`timescale 1ns/1ps

module access_dispatch (
    input  logic           aclk,
    input  logic           aresetn,
    sramx_if.slave         cpu,
    input  mmu_pkg::word_t i_paddr,
    input  logic           i_uncached,
    sramx_if.master        cached_bus,
    sramx_if.master        uncached_bus
);
    import mmu_pkg::*;

    // pipeline state
    logic data_done;      // data stage holds no pending response
    logic data_uncached;  // pending response comes from the uncached side

    logic  sel_addr_ok;   // addr_ok of the target chosen for the request stage
    logic  sel_data_ok;   // data_ok of the target owning the data stage
    word_t sel_rdata;
    logic  data_ready;    // data stage empty or retiring this cycle
    logic  stage_ready;   // request stage can move into the data stage
    logic  issue;         // forward req to a target

    assign sel_addr_ok = i_uncached ? uncached_bus.addr_ok : cached_bus.addr_ok;
    assign sel_data_ok = data_uncached ? uncached_bus.data_ok : cached_bus.data_ok;
    assign sel_rdata   = data_uncached ? uncached_bus.rdata : cached_bus.rdata;

    assign data_ready  = data_done || sel_data_ok;
    assign stage_ready = data_ready && sel_addr_ok;

    // hold req back while the other target still owes a response,
    // otherwise a fast cached reply could overtake a slow uncached one
    assign issue = cpu.req && data_ready;

    assign cpu.addr_ok = cpu.req && stage_ready;
    assign cpu.data_ok = !data_done && sel_data_ok;
    assign cpu.rdata   = sel_rdata;

    // cached target
    assign cached_bus.req   = issue && !i_uncached;
    assign cached_bus.wr    = cpu.wr;
    assign cached_bus.addr  = i_paddr;
    assign cached_bus.wdata = cpu.wdata;

    // uncached target
    assign uncached_bus.req   = issue && i_uncached;
    assign uncached_bus.wr    = cpu.wr;
    assign uncached_bus.addr  = i_paddr;
    assign uncached_bus.wdata = cpu.wdata;

    always_ff @(posedge aclk) begin
        if (aresetn) begin  // synchronous, active high
            data_done     <= 1'b1;  // data stage starts empty
            data_uncached <= 1'b0;
        end else if (cpu.addr_ok) begin
            // request moves into the data stage
            data_done     <= 1'b0;
            data_uncached <= i_uncached;
        end else if (sel_data_ok) begin
            data_done <= 1'b1;
        end
    end

endmodule

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic   aclk,
    input  logic   aresetn,
    sramx_if.slave bus
);
    import mmu_pkg::*;

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    word_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             accept;
    logic             data_ok_q;
    word_t            rdata_q;

    // word index, wraps at RAM_WORDS
    assign idx = IDX_W'((bus.addr >> 2) % RAM_WORDS);

    assign accept      = bus.req && bus.addr_ok;
    assign bus.addr_ok = bus.req;  // never stalls
    assign bus.data_ok = data_ok_q;
    assign bus.rdata   = rdata_q;

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= accept;  // response exactly one cycle later
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            if (bus.wr) begin
                mem[idx] <= bus.wdata;
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

endmodule

/* mmio_dev.sv */
`timescale 1ns/1ps

module mmio_dev #(
    parameter int UNCACHED_LATENCY = 3
) (
    input  logic   aclk,
    input  logic   aresetn,
    sramx_if.slave bus
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(MMIO_WORDS);
    localparam int CNT_W = (UNCACHED_LATENCY > 1) ? $clog2(UNCACHED_LATENCY) : 1;

    if (UNCACHED_LATENCY < 1) begin : g_bad_latency
        $error("mmio_dev needs UNCACHED_LATENCY of at least 1");
    end

    word_t            regs [MMIO_WORDS];
    logic             busy;
    logic [CNT_W-1:0] cnt;        // cycles left before the finishing edge
    logic             accept;
    logic             finish;
    logic [IDX_W-1:0] idx;
    logic             wr_q;
    logic [IDX_W-1:0] idx_q;
    word_t            wdata_q;
    logic             op_wr;
    logic [IDX_W-1:0] op_idx;
    word_t            op_wdata;
    logic             data_ok_q;
    word_t            rdata_q;

    assign idx = IDX_W'((bus.addr >> 2) % MMIO_WORDS);

    assign bus.addr_ok = bus.req && !busy;  // one access at a time
    assign accept      = bus.req && bus.addr_ok;
    assign bus.data_ok = data_ok_q;
    assign bus.rdata   = rdata_q;

    // with latency 1 the access completes straight from the bus fields
    assign op_wr    = busy ? wr_q : bus.wr;
    assign op_idx   = busy ? idx_q : idx;
    assign op_wdata = busy ? wdata_q : bus.wdata;
    assign finish   = busy ? (cnt == CNT_W'(1)) : (accept && UNCACHED_LATENCY == 1);

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            busy      <= 1'b0;
            cnt       <= '0;
            data_ok_q <= 1'b0;
            for (int i = 0; i < MMIO_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            data_ok_q <= finish;
            if (accept && !finish) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(UNCACHED_LATENCY - 1);
            end else if (busy) begin
                if (finish) begin
                    busy <= 1'b0;  // free again in the data_ok cycle
                end else begin
                    cnt <= cnt - CNT_W'(1);
                end
            end
            if (finish && op_wr) begin
                regs[op_idx] <= op_wdata;  // store lands at the end of the count
            end
        end
    end

    // request payload
    always_ff @(posedge aclk) begin
        if (accept) begin
            wr_q    <= bus.wr;
            idx_q   <= idx;
            wdata_q <= bus.wdata;
        end
        if (finish && !op_wr) begin
            rdata_q <= regs[op_idx];
        end
    end

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int RAM_WORDS        = 256,
    parameter int UNCACHED_LATENCY = 3
) (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic           i_req,
    input  logic           i_wr,
    input  mmu_pkg::word_t i_addr,
    input  mmu_pkg::word_t i_wdata,
    output logic           o_addr_ok,
    output logic           o_data_ok,
    output mmu_pkg::word_t o_rdata
);
    import mmu_pkg::*;

    word_t paddr;
    logic  uncached;

    sramx_if cpu_bus ();
    sramx_if cached_bus ();
    sramx_if uncached_bus ();

    // cpu side
    assign cpu_bus.req   = i_req;
    assign cpu_bus.wr    = i_wr;
    assign cpu_bus.addr  = i_addr;
    assign cpu_bus.wdata = i_wdata;
    assign o_addr_ok     = cpu_bus.addr_ok;
    assign o_data_ok     = cpu_bus.data_ok;
    assign o_rdata       = cpu_bus.rdata;

    addr_translate translate_i (
        .i_vaddr    (cpu_bus.addr),
        .o_paddr    (paddr),
        .o_uncached (uncached)
    );

    access_dispatch dispatch_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .cpu          (cpu_bus.slave),
        .i_paddr      (paddr),
        .i_uncached   (uncached),
        .cached_bus   (cached_bus.master),
        .uncached_bus (uncached_bus.master)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) data_ram_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .bus     (cached_bus.slave)
    );

    mmio_dev #(
        .UNCACHED_LATENCY (UNCACHED_LATENCY)
    ) mmio_dev_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .bus     (uncached_bus.slave)
    );

endmodule

/* mem_subsys_assert.sv */
`timescale 1ns/1ps

module mem_subsys_assert (
    input logic           aclk,
    input logic           aresetn,
    input logic           i_req,
    input logic           i_wr,
    input mmu_pkg::word_t i_addr,
    input mmu_pkg::word_t i_wdata,
    input logic           o_addr_ok,
    input logic           o_data_ok
);
    logic [7:0] outstanding;  // accepted requests still owed a data_ok

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            outstanding <= '0;
        end else if ((i_req && o_addr_ok) && !o_data_ok) begin
            outstanding <= outstanding + 8'd1;
        end else if (!(i_req && o_addr_ok) && o_data_ok) begin
            outstanding <= outstanding - 8'd1;
        end
    end

    a_data_ok_pending: assert property (@(posedge aclk) disable iff (aresetn)
        o_data_ok |-> outstanding != 0)
        else $error("o_data_ok without an outstanding request");

    a_addr_ok_req: assert property (@(posedge aclk) disable iff (aresetn)
        o_addr_ok |-> i_req)
        else $error("o_addr_ok high while i_req is low");

    // fields hold until the request is taken
    a_req_stable: assert property (@(posedge aclk) disable iff (aresetn)
        (i_req && !o_addr_ok) |=> (i_req && $stable(i_wr) && $stable(i_addr)
                                   && $stable(i_wdata)))
        else $error("request changed before acceptance");

endmodule

bind mem_subsys_top mem_subsys_assert assert_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_req     (i_req),
    .i_wr      (i_wr),
    .i_addr    (i_addr),
    .i_wdata   (i_wdata),
    .o_addr_ok (o_addr_ok),
    .o_data_ok (o_data_ok)
);

/* tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;
    import mmu_pkg::*;

    localparam int RAM_WORDS        = 200;  // not a power of two so high address bits reach the index
    localparam int UNCACHED_LATENCY = 3;
    localparam int TIMEOUT          = 50;  // cycles allowed per wait

    // expected response queued at acceptance
    typedef struct packed {
        logic        is_read;
        logic        check;     // compare rdata only for words the model knows
        logic        uncached;
        word_t       data;
        logic [31:0] acc_cyc;
    } resp_t;

    logic  aclk;
    logic  aresetn;
    logic  i_req;
    logic  i_wr;
    word_t i_addr;
    word_t i_wdata;
    logic  o_addr_ok;
    logic  o_data_ok;
    word_t o_rdata;

    // reference model
    word_t ram_model  [RAM_WORDS];
    logic  ram_valid  [RAM_WORDS];
    word_t mmio_model [MMIO_WORDS];

    resp_t pend_q [$];
    resp_t next_resp;  // expectation for the request on the bus
    int    cyc;
    int    errors;
    int    checks;
    int    tests;
    int    seed;
    logic  aborted;

    mem_subsys_top #(
        .RAM_WORDS        (RAM_WORDS),
        .UNCACHED_LATENCY (UNCACHED_LATENCY)
    ) mem_subsys_top_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_req     (i_req),
        .i_wr      (i_wr),
        .i_addr    (i_addr),
        .i_wdata   (i_wdata),
        .o_addr_ok (o_addr_ok),
        .o_data_ok (o_data_ok),
        .o_rdata   (o_rdata)
    );

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    // pops one expected response per data_ok
    always @(posedge aclk) begin
        resp_t r;
        int    lat;
        int    exp_lat;
        if (aresetn) begin
            pend_q.delete();  // reset drops every outstanding response
        end else begin
            if (o_data_ok) begin
                if (pend_q.size() == 0) begin
                    $display("o_data_ok at %0t while no request is outstanding", $time);
                    errors++;
                end else begin
                    r       = pend_q.pop_front();
                    lat     = cyc - int'(r.acc_cyc);
                    exp_lat = r.uncached ? UNCACHED_LATENCY : 1;
                    checks++;
                    if (lat != exp_lat) begin
                        $display("Mismatch at %0t: o_data_ok latency got %0d expected %0d",
                                 $time, lat, exp_lat);
                        errors++;
                    end
                    if (r.is_read && r.check) begin
                        checks++;
                        if (o_rdata !== r.data) begin
                            $display("Mismatch at %0t: o_rdata got %h expected %h",
                                     $time, o_rdata, r.data);
                            errors++;
                        end
                    end
                end
            end
            if (i_req && o_addr_ok) begin
                r         = next_resp;
                r.acc_cyc = cyc;
                pend_q.push_back(r);
            end
        end
        cyc++;
    end

    // gives target and word index by the fixed segment mapping
    task automatic locate(input word_t vaddr, output logic unc, output int idx);
        word_t paddr;
        unc = 1'b0;
        if (!vaddr[31]) begin
            paddr = vaddr + KUSEG_OFFSET;  // kuseg
        end else if (vaddr[31:30] == 2'b10) begin
            paddr = {3'b000, vaddr[28:0]};
            unc   = vaddr[29];  // kseg1
        end else begin
            paddr = vaddr;
        end
        idx = unc ? int'((paddr >> 2) % MMIO_WORDS) : int'((paddr >> 2) % RAM_WORDS);
    endtask

    // puts one request on the bus and leaves req high after its acceptance
    task automatic issue(input logic wr, input word_t vaddr, input word_t wdata);
        resp_t r;
        logic  unc;
        int    idx;
        int    waited;
        if (aborted) begin
            return;
        end
        locate(vaddr, unc, idx);
        r          = '0;
        r.is_read  = !wr;
        r.uncached = unc;
        if (wr) begin
            if (unc) begin
                mmio_model[idx] = wdata;
            end else begin
                ram_model[idx] = wdata;
                ram_valid[idx] = 1'b1;
            end
        end else if (unc) begin
            r.data  = mmio_model[idx];
            r.check = 1'b1;
        end else begin
            r.data  = ram_model[idx];
            r.check = ram_valid[idx];
        end
        @(negedge aclk);
        i_req     = 1'b1;
        i_wr      = wr;
        i_addr    = vaddr;
        i_wdata   = wdata;
        next_resp = r;
        waited    = 0;
        do begin
            @(posedge aclk);
            waited++;
        end while (!o_addr_ok && waited < TIMEOUT);
        if (!o_addr_ok) begin
            $display("timeout at %0t: o_addr_ok never came for address %h", $time, vaddr);
            errors++;
            aborted = 1'b1;
        end
    endtask

    // drops req and waits until every response has arrived
    task automatic drain();
        int waited;
        if (aborted) begin
            return;
        end
        @(negedge aclk);
        i_req  = 1'b0;
        waited = 0;
        while (pend_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge aclk);
            waited++;
        end
        if (pend_q.size() != 0) begin
            $display("timeout at %0t: %0d responses never arrived", $time, pend_q.size());
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic access_one(input logic wr, input word_t vaddr, input word_t wdata);
        issue(wr, vaddr, wdata);
        drain();
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    task automatic cached_rw();
        int e0;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            access_one(1'b1, 32'h8000_0100 + i * 4, $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            access_one(1'b0, 32'h8000_0100 + i * 4, '0);
        end
        report_test("kseg0 cached", e0);
    endtask

    task automatic uncached_rw();
        int e0;
        e0 = errors;
        access_one(1'b0, 32'hA000_003C, '0);  // never written so reads zero
        for (int i = 0; i < 8; i++) begin
            access_one(1'b1, 32'hA000_0000 + i * 4, $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            access_one(1'b0, 32'hA000_0000 + i * 4, '0);
        end
        report_test("kseg1 uncached", e0);
    endtask

    task automatic alias_segments();
        int   e0;
        logic unc;
        int   idx;
        e0 = errors;
        access_one(1'b1, 32'h8000_0008, 32'h1111_aaaa);
        access_one(1'b1, 32'hA000_0008, 32'h2222_bbbb);
        access_one(1'b1, 32'h8000_0008, 32'h3333_cccc);  // must leave kseg1 word alone
        access_one(1'b0, 32'hA000_0008, '0);
        access_one(1'b0, 32'h8000_0008, '0);
        // kuseg 0x40 lands on physical 0x4000_0040 and is read back through kseg0
        access_one(1'b1, 32'h0000_0040, 32'h4444_dddd);
        locate(32'h0000_0040, unc, idx);
        access_one(1'b0, 32'h8000_0000 + idx * 4, '0);
        access_one(1'b1, 32'hC000_0044, 32'h5555_eeee);  // kseg2 maps by identity
        locate(32'hC000_0044, unc, idx);
        access_one(1'b0, 32'h8000_0000 + idx * 4, '0);
        report_test("aliasing and segments", e0);
    endtask

    task automatic back_to_back();
        int e0;
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            issue(1'b1, 32'h8000_0200 + i * 4, $random(seed));
            issue(1'b1, 32'hA000_0010 + i * 4, $random(seed));
        end
        for (int i = 0; i < 6; i++) begin
            issue(1'b0, 32'h8000_0200 + i * 4, '0);
            issue(1'b0, 32'hA000_0010 + i * 4, '0);
        end
        drain();
        report_test("back to back", e0);
    endtask

    task automatic random_mix();
        int          e0;
        logic [31:0] rnd;
        word_t       addr;
        e0 = errors;
        for (int n = 0; n < 200; n++) begin
            rnd  = $random(seed);
            addr = {rnd[31:29], 21'd0, rnd[5:0], 2'b00};  // small window so words collide
            issue(rnd[8], addr, $random(seed));
            if (rnd[13:12] == 2'b00) begin
                drain();
            end
        end
        drain();
        report_test("random mix", e0);
    endtask

    task automatic mid_run_reset();
        int e0;
        e0 = errors;
        issue(1'b0, 32'hA000_0004, '0);  // still in flight when reset hits
        @(negedge aclk);
        i_req   = 1'b0;
        aresetn = 1'b1;
        repeat (10) @(negedge aclk);
        aresetn = 1'b0;
        for (int i = 0; i < MMIO_WORDS; i++) begin
            mmio_model[i] = '0;
        end
        repeat (4) begin
            @(posedge aclk);
            checks++;
            if (o_addr_ok !== 1'b0 || o_data_ok !== 1'b0) begin
                $display("Mismatch at %0t: o_addr_ok/o_data_ok got %b%b expected 00",
                         $time, o_addr_ok, o_data_ok);
                errors++;
            end
        end
        for (int i = 0; i < MMIO_WORDS; i++) begin
            access_one(1'b0, 32'hA000_0000 + i * 4, '0);
        end
        report_test("reset", e0);
    endtask

    initial begin
        seed      = 28244;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        aborted   = 1'b0;
        next_resp = '0;
        aresetn   = 1'b1;
        i_req     = 1'b0;
        i_wr      = 1'b0;
        i_addr    = '0;
        i_wdata   = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_valid[i] = 1'b0;
        end
        for (int i = 0; i < MMIO_WORDS; i++) begin
            mmio_model[i] = '0;
        end
        repeat (10) @(negedge aclk);
        aresetn = 1'b0;

        cached_rw();
        uncached_rw();
        alias_segments();
        back_to_back();
        random_mix();
        mid_run_reset();

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* compile.f */
mmu_pkg.sv
sramx_if.sv
addr_translate.sv
access_dispatch.sv
data_ram.sv
mmio_dev.sv
mem_subsys_top.sv
mem_subsys_assert.sv
tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - files:
      - mmu_pkg.sv
      - sramx_if.sv
      - addr_translate.sv
      - access_dispatch.sv
      - data_ram.sv
      - mmio_dev.sv
      - mem_subsys_top.sv
  - target: test
    files:
      - mem_subsys_assert.sv
      - tb_mem_subsys.sv
